// ==== hw/panel_defs.svh ====
//////////////////////////////////////////////////
// Panel geometry, pixel size and command opcodes
//////////////////////////////////////////////////
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// Panel geometry.
`define PANEL_WIDTH     8
`define PANEL_HEIGHT    4
`define BYTES_PER_PIXEL 2

// Command opcodes.
`define OP_FILL_PANEL   8'h01
`define OP_FILL_AREA    8'h02

// Framebuffer size in bytes.
`define FB_DEPTH        (`PANEL_WIDTH * `PANEL_HEIGHT * `BYTES_PER_PIXEL)

`endif

// ==== hw/panel_pkg.sv ====
//////////////////////////////////////////////////
// Shared index, address and colour types
//////////////////////////////////////////////////
`default_nettype none
`include "panel_defs.svh"

package panel_pkg;

    localparam int unsigned COL_BITS  = (`PANEL_WIDTH > 1) ? $clog2(`PANEL_WIDTH) : 1;
    localparam int unsigned ROW_BITS  = (`PANEL_HEIGHT > 1) ? $clog2(`PANEL_HEIGHT) : 1;
    localparam int unsigned PIX_BITS  = (`BYTES_PER_PIXEL > 1) ? $clog2(`BYTES_PER_PIXEL) : 1;
    localparam int unsigned ADDR_BITS = (`FB_DEPTH > 1) ? $clog2(`FB_DEPTH) : 1;

    typedef logic [COL_BITS-1:0]            column_t;   // Column index.
    typedef logic [ROW_BITS-1:0]            row_t;      // Row index.
    typedef logic [PIX_BITS-1:0]            pixel_t;    // Byte within a pixel.
    typedef logic [`BYTES_PER_PIXEL*8-1:0]  color_t;    // First byte at the top.
    typedef logic [ADDR_BITS-1:0]           fb_addr_t;  // Framebuffer byte address.

endpackage

`default_nettype wire

// ==== hw/framebuffer_ram.sv ====
//////////////////////////////////////////////////
// Byte-wide framebuffer, one write port and one
// registered read port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "panel_defs.svh"

module framebuffer_ram (
    input  wire logic                clk,
    input  wire logic                wr_en,
    input  panel_pkg::fb_addr_t      wr_addr,
    input  wire logic [7:0]          wr_data,
    input  panel_pkg::fb_addr_t      rd_addr,
    output logic [7:0]               rd_data
);

    logic [7:0] mem [`FB_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];                            // One cycle read latency.
    end

endmodule

`default_nettype wire

// ==== hw/fill_area_engine.sv ====
//////////////////////////////////////////////////
// Area engine: walks a clipped rectangle and
// writes one framebuffer byte per cycle
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "panel_defs.svh"

module fill_area_engine (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                start,
    input  panel_pkg::column_t       x1,
    input  panel_pkg::row_t          y1,
    input  wire logic [7:0]          width,
    input  wire logic [7:0]          height,
    input  panel_pkg::color_t        color,
    output panel_pkg::fb_addr_t      wr_addr,
    output logic [7:0]               wr_data,
    output logic                     wr_en,
    output logic                     finished
);

    logic [8:0]          x_sum;
    logic [8:0]          y_sum;
    logic [8:0]          x_end;
    logic [8:0]          y_end;
    logic                area_empty;
    logic                active;
    logic                empty_fin;
    logic                last_write;
    panel_pkg::column_t  col_first;
    panel_pkg::column_t  col_last;
    panel_pkg::row_t     row_last;
    panel_pkg::column_t  col;
    panel_pkg::row_t     row;
    panel_pkg::pixel_t   pix;
    int unsigned         addr_full;

    //////////////////////////////////////////////////
    // Clipping
    //////////////////////////////////////////////////
    assign x_sum      = 9'(x1) + {1'b0, width};
    assign y_sum      = 9'(y1) + {1'b0, height};
    assign x_end      = (x_sum > 9'(`PANEL_WIDTH)) ? 9'(`PANEL_WIDTH) : x_sum;
    assign y_end      = (y_sum > 9'(`PANEL_HEIGHT)) ? 9'(`PANEL_HEIGHT) : y_sum;
    assign area_empty = (x_end <= 9'(x1)) || (y_end <= 9'(y1));

    //////////////////////////////////////////////////
    // Walk
    //////////////////////////////////////////////////
    assign last_write = (pix == panel_pkg::pixel_t'(`BYTES_PER_PIXEL - 1))
                        && (col == col_last) && (row == row_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            empty_fin <= 1'b0;
        end else begin
            empty_fin <= 1'b0;
            if (start) begin
                active    <= !area_empty;
                empty_fin <= area_empty;                    // Nothing to draw.
            end else if (active && last_write) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            col_first <= x1;
            col_last  <= panel_pkg::column_t'(x_end - 9'd1);
            row_last  <= panel_pkg::row_t'(y_end - 9'd1);
            col       <= x1;
            row       <= y1;
            pix       <= '0;
        end else if (active) begin
            if (pix == panel_pkg::pixel_t'(`BYTES_PER_PIXEL - 1)) begin
                pix <= '0;
                if (col == col_last) begin
                    col <= col_first;                       // Next row.
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                pix <= pix + 1'b1;
            end
        end
    end

    assign addr_full = (int'(row) * `PANEL_WIDTH + int'(col)) * `BYTES_PER_PIXEL + int'(pix);
    assign wr_addr   = panel_pkg::fb_addr_t'(addr_full);
    assign wr_data   = color[8 * (`BYTES_PER_PIXEL - 1 - int'(pix)) +: 8];  // Byte 0 is MSB.
    assign wr_en     = active;
    assign finished  = (active && last_write) || empty_fin;

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> addr_full < `FB_DEPTH);

endmodule

`default_nettype wire

// ==== hw/cmd_fill.sv ====
//////////////////////////////////////////////////
// Fill command: collects the colour, selects the
// bounds and runs the area engine until done
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "panel_defs.svh"

module cmd_fill (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [7:0]          color_byte,
    input  wire logic                color_valid,
    input  wire logic                use_area,
    input  panel_pkg::column_t       area_x,
    input  panel_pkg::row_t          area_y,
    input  wire logic [7:0]          area_width,
    input  wire logic [7:0]          area_height,
    output logic                     busy,
    output logic                     done,
    output panel_pkg::fb_addr_t      wr_addr,
    output logic [7:0]               wr_data,
    output logic                     wr_en
);

    typedef enum logic [2:0] {
        ST_CAPTURE, ST_START, ST_RUNNING, ST_PREDONE, ST_DONE
    } fill_state_t;

    fill_state_t         state;
    panel_pkg::pixel_t   byte_cnt;
    panel_pkg::color_t   color_q;
    panel_pkg::column_t  sel_x;
    panel_pkg::row_t     sel_y;
    logic [7:0]          sel_w;
    logic [7:0]          sel_h;
    logic                engine_start;
    logic                engine_finished;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_CAPTURE;
            byte_cnt     <= '0;
            engine_start <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
        end else begin
            case (state)
                ST_CAPTURE: if (color_valid) begin
                    busy <= 1'b1;
                    if (byte_cnt == panel_pkg::pixel_t'(`BYTES_PER_PIXEL - 1)) begin
                        byte_cnt     <= '0;
                        engine_start <= 1'b1;
                        state        <= ST_START;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                ST_START: begin
                    engine_start <= 1'b0;
                    state        <= ST_RUNNING;
                end
                ST_RUNNING: if (engine_finished) state <= ST_PREDONE;
                ST_PREDONE: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    done  <= 1'b0;
                    state <= ST_CAPTURE;
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

    // Colour shift register and bound selection.
    always_ff @(posedge clk) begin
        if (state == ST_CAPTURE && color_valid) begin
            color_q <= (color_q << 8) | panel_pkg::color_t'(color_byte);  // MSB first.
            sel_x   <= use_area ? area_x : '0;
            sel_y   <= use_area ? area_y : '0;
            sel_w   <= use_area ? area_width : 8'(`PANEL_WIDTH);
            sel_h   <= use_area ? area_height : 8'(`PANEL_HEIGHT);
        end else if (state == ST_DONE) begin
            color_q <= '0;
        end
    end

    fill_area_engine u_engine (
        .clk     (clk),
        .reset   (reset),
        .start   (engine_start),
        .x1      (sel_x),
        .y1      (sel_y),
        .width   (sel_w),
        .height  (sel_h),
        .color   (color_q),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .finished(engine_finished)
    );

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (reset) engine_start |-> !wr_en);

endmodule

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
//////////////////////////////////////////////////
// Command decoder: opcode, FILL_AREA geometry,
// colour byte forwarding to the fill stage
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "panel_defs.svh"

module cmd_decoder (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [7:0]          data_in,
    input  wire logic                enable,
    output logic                     ready_for_data,
    input  wire logic                busy,
    output logic [7:0]               color_byte,
    output logic                     color_valid,
    output logic                     use_area,
    output panel_pkg::column_t       area_x,
    output panel_pkg::row_t          area_y,
    output logic [7:0]               area_width,
    output logic [7:0]               area_height
);

    typedef enum logic [2:0] {
        ST_OPCODE, ST_X, ST_Y, ST_WIDTH, ST_HEIGHT, ST_COLOR, ST_WAIT
    } dec_state_t;

    dec_state_t        state;
    panel_pkg::pixel_t color_cnt;
    logic              take;

    assign take        = enable && ready_for_data;
    assign color_valid = take && (state == ST_COLOR);
    assign color_byte  = data_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= ST_OPCODE;
            ready_for_data <= 1'b1;
            use_area       <= 1'b0;
            color_cnt      <= '0;
        end else begin
            case (state)
                ST_OPCODE: if (take) begin
                    if (data_in == `OP_FILL_PANEL) begin
                        use_area <= 1'b0;
                        state    <= ST_COLOR;
                    end else if (data_in == `OP_FILL_AREA) begin
                        use_area <= 1'b1;
                        state    <= ST_X;
                    end                                    // Anything else is a no-op.
                end
                ST_X:      if (take) state <= ST_Y;
                ST_Y:      if (take) state <= ST_WIDTH;
                ST_WIDTH:  if (take) state <= ST_HEIGHT;
                ST_HEIGHT: if (take) state <= ST_COLOR;
                ST_COLOR: if (take) begin
                    if (color_cnt == panel_pkg::pixel_t'(`BYTES_PER_PIXEL - 1)) begin
                        color_cnt      <= '0;
                        ready_for_data <= 1'b0;            // Hold off until the fill ends.
                        state          <= ST_WAIT;
                    end else begin
                        color_cnt <= color_cnt + 1'b1;
                    end
                end
                ST_WAIT: if (!busy) begin
                    ready_for_data <= 1'b1;
                    state          <= ST_OPCODE;
                end
                default: state <= ST_OPCODE;
            endcase
        end
    end

    // Geometry registers.
    always_ff @(posedge clk) begin
        if (take) begin
            if (state == ST_X)      area_x      <= panel_pkg::column_t'(data_in);
            if (state == ST_Y)      area_y      <= panel_pkg::row_t'(data_in);
            if (state == ST_WIDTH)  area_width  <= data_in;
            if (state == ST_HEIGHT) area_height <= data_in;
        end
    end

    a_no_enable_when_stalled: assert property (
        @(posedge clk) disable iff (reset) enable |-> ready_for_data);

    // The first colour byte must not reach a fill stage still busy.
    a_color_when_fill_idle: assert property (
        @(posedge clk) disable iff (reset)
        color_valid |-> (color_cnt != '0 || !busy));

endmodule

`default_nettype wire

// ==== hw/panel_cmd_top.sv ====
//////////////////////////////////////////////////
// LED panel command front end top level
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module panel_cmd_top (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic [7:0]          data_in,
    input  wire logic                enable,
    output logic                     ready_for_data,
    output logic                     done,
    input  panel_pkg::fb_addr_t      rd_addr,
    output logic [7:0]               rd_data
);

    logic [7:0]           color_byte;
    logic                 color_valid;
    logic                 use_area;
    panel_pkg::column_t   area_x;
    panel_pkg::row_t      area_y;
    logic [7:0]           area_width;
    logic [7:0]           area_height;
    logic                 busy;
    panel_pkg::fb_addr_t  wr_addr;
    logic [7:0]           wr_data;
    logic                 wr_en;

    cmd_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in),
        .enable        (enable),
        .ready_for_data(ready_for_data),
        .busy          (busy),
        .color_byte    (color_byte),
        .color_valid   (color_valid),
        .use_area      (use_area),
        .area_x        (area_x),
        .area_y        (area_y),
        .area_width    (area_width),
        .area_height   (area_height)
    );

    cmd_fill u_fill (
        .clk        (clk),
        .reset      (reset),
        .color_byte (color_byte),
        .color_valid(color_valid),
        .use_area   (use_area),
        .area_x     (area_x),
        .area_y     (area_y),
        .area_width (area_width),
        .area_height(area_height),
        .busy       (busy),
        .done       (done),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_en      (wr_en)
    );

    framebuffer_ram u_fb (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== tb/panel_checker.sv ====
//////////////////////////////////////////////////
// Reference framebuffer model, handshake and
// readback checks for the panel command front end
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "panel_defs.svh"

module panel_checker (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic [7:0]     data_in,
    input  wire logic           enable,
    input  wire logic           ready_for_data,
    input  wire logic           done,
    input  panel_pkg::fb_addr_t rd_addr,
    input  wire logic           rd_valid,
    input  wire logic [7:0]     rd_data,
    output int                  error_count,
    output int                  check_count,
    output int                  done_count
);

    localparam int W     = `PANEL_WIDTH;
    localparam int H     = `PANEL_HEIGHT;
    localparam int B     = `BYTES_PER_PIXEL;
    localparam int DEPTH = `FB_DEPTH;

    logic [7:0]          model [DEPTH];
    logic [7:0]          geom [4];                          // x1, y1, width, height.
    logic [7:0]          color_bytes [B];                   // Index 0 arrives first.
    int                  parse_state;                       // 0 opcode, 1..4 geometry, 5 colour.
    int                  color_idx;
    bit                  is_area;
    bit                  pending;
    bit                  expect_high;
    bit                  ready_flagged;
    bit                  check_q;
    panel_pkg::fb_addr_t addr_q;

    task automatic apply_fill();
        int x_lo;
        int y_lo;
        int x_hi;
        int y_hi;
        x_lo = is_area ? int'(geom[0]) : 0;
        y_lo = is_area ? int'(geom[1]) : 0;
        x_hi = is_area ? x_lo + int'(geom[2]) : W;
        y_hi = is_area ? y_lo + int'(geom[3]) : H;
        if (x_hi > W) x_hi = W;                             // Clip at the panel edge.
        if (y_hi > H) y_hi = H;
        for (int r = y_lo; r < y_hi; r++)
            for (int c = x_lo; c < x_hi; c++)
                for (int p = 0; p < B; p++)
                    model[(r * W + c) * B + p] = color_bytes[p];
    endtask

    task automatic parse_byte(input logic [7:0] b);
        if (parse_state == 0) begin
            if (b == `OP_FILL_PANEL) begin
                is_area     = 1'b0;
                parse_state = 5;
            end else if (b == `OP_FILL_AREA) begin
                is_area     = 1'b1;
                parse_state = 1;
            end
            color_idx = 0;
        end else if (parse_state < 5) begin
            geom[parse_state - 1] = b;
            parse_state++;
        end else begin
            color_bytes[color_idx] = b;
            color_idx++;
            if (color_idx == B) begin
                apply_fill();
                pending       = 1'b1;
                ready_flagged = 1'b0;
                parse_state   = 0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            parse_state = 0;
            color_idx   = 0;
            pending     = 1'b0;
            expect_high = 1'b0;
            check_q     = 1'b0;
            error_count = 0;
            check_count = 0;
            done_count  = 0;
        end else begin
            if (check_q) begin                              // Read data lags by one cycle.
                check_count++;
                if (rd_data !== model[addr_q]) begin
                    $display("mismatch at %0t: rd_data[%0d] expected %02h actual %02h",
                             $time, addr_q, model[addr_q], rd_data);
                    error_count++;
                end
            end
            check_q = rd_valid;
            addr_q  = rd_addr;

            if (expect_high && !ready_for_data) begin
                $display("ready_for_data did not return high the cycle after done at %0t", $time);
                error_count++;
            end
            expect_high = 1'b0;

            if (done) done_count++;
            if (pending) begin
                if (ready_for_data && !ready_flagged) begin
                    $display("ready_for_data went high before done at %0t", $time);
                    error_count++;
                    ready_flagged = 1'b1;
                end
                if (done) begin
                    pending     = 1'b0;
                    expect_high = 1'b1;
                end
            end else if (done) begin
                $display("done pulsed with no command in progress at %0t", $time);
                error_count++;
            end

            if (enable && ready_for_data) parse_byte(data_in);
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_panel_cmd.sv ====
//////////////////////////////////////////////////
// Testbench for the panel command front end
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "panel_defs.svh"

module tb_panel_cmd;

    localparam int W       = `PANEL_WIDTH;
    localparam int H       = `PANEL_HEIGHT;
    localparam int B       = `BYTES_PER_PIXEL;
    localparam int DEPTH   = `FB_DEPTH;
    localparam int TIMEOUT = 2000;

    logic                clk;
    logic                reset;
    logic [7:0]          data_in;
    logic                enable;
    logic                ready_for_data;
    logic                done;
    panel_pkg::fb_addr_t rd_addr;
    logic [7:0]          rd_data;
    logic                rd_valid;
    int                  seed;
    int                  tb_errors;
    int                  cmd_count;
    int                  test_num;
    int                  err_mark;
    int                  chk_errors;
    int                  chk_reads;
    int                  chk_dones;
    int                  x;
    int                  y;

    panel_cmd_top u_panel_cmd_top (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in),
        .enable        (enable),
        .ready_for_data(ready_for_data),
        .done          (done),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    panel_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .data_in       (data_in),
        .enable        (enable),
        .ready_for_data(ready_for_data),
        .done          (done),
        .rd_addr       (rd_addr),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .error_count   (chk_errors),
        .check_count   (chk_reads),
        .done_count    (chk_dones)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!ready_for_data && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready_for_data) begin
            $display("timeout: ready_for_data stayed low for %0d cycles", TIMEOUT);
            tb_errors++;
        end else begin
            @(posedge clk);
            data_in <= b;
            enable  <= 1'b1;
            @(posedge clk);
            enable  <= 1'b0;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: done never pulsed within %0d cycles", TIMEOUT);
            tb_errors++;
        end
    endtask

    task automatic read_back();
        for (int a = 0; a < DEPTH; a++) begin
            @(posedge clk);
            rd_addr  <= panel_pkg::fb_addr_t'(a);
            rd_valid <= 1'b1;
        end
        @(posedge clk);
        rd_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);                                     // Last compare has landed.
    endtask

    task automatic run_command(input bit area, input int w, input int h);
        panel_pkg::color_t c;
        c = panel_pkg::color_t'($random(seed));
        cmd_count++;
        send_byte(area ? `OP_FILL_AREA : `OP_FILL_PANEL);
        if (area) begin
            send_byte(8'(x));
            send_byte(8'(y));
            send_byte(8'(w));
            send_byte(8'(h));
        end
        for (int p = 0; p < B; p++)
            send_byte(c[8 * (B - 1 - p) +: 8]);             // MSB first.
        wait_done();
        read_back();
    endtask

    task automatic send_noops(input int n);
        logic [7:0] b;
        repeat (n) begin
            b = 8'(rand_below(256));
            if (b == `OP_FILL_PANEL || b == `OP_FILL_AREA) b = b + 8'h10;
            send_byte(b);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (total_errors() == err_mark)
            $display("test %0d %s: pass", test_num, name);
        else
            $display("test %0d %s: fail, %0d new errors", test_num, name,
                     total_errors() - err_mark);
        err_mark = total_errors();
    endtask

    initial begin
        seed      = 32'he20f_51e5;
        tb_errors = 0;
        cmd_count = 0;
        test_num  = 0;
        err_mark  = 0;
        x         = 0;
        y         = 0;
        reset     = 1'b1;
        data_in   = 8'h00;
        enable    = 1'b0;
        rd_addr   = '0;
        rd_valid  = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        if (!ready_for_data) begin
            $display("ready_for_data is low after reset");
            tb_errors++;
        end
        run_command(1'b0, 0, 0);
        end_test("fill panel");

        x = rand_below(W);
        y = rand_below(H);
        run_command(1'b1, 1 + rand_below(W - x), 1 + rand_below(H - y));
        end_test("area inside panel");

        x = rand_below(W);
        y = rand_below(H);
        run_command(1'b1, W - x + 1 + rand_below(4), H - y + 1 + rand_below(4));
        x = rand_below(W);
        y = rand_below(H);
        run_command(1'b1, 0, 1 + rand_below(H));            // Zero width.
        run_command(1'b1, 1 + rand_below(W), 0);            // Zero height.
        end_test("clipped and empty areas");

        send_noops(1 + rand_below(4));
        x = rand_below(W);
        y = rand_below(H);
        run_command(1'b1, 1 + rand_below(W), 1 + rand_below(H));
        end_test("no-op opcodes before a command");

        repeat (20) begin
            if (rand_below(2) == 1) send_noops(1 + rand_below(3));
            x = rand_below(W);
            y = rand_below(H);
            run_command(rand_below(3) != 0, rand_below(W + 3), rand_below(H + 3));
        end
        if (chk_dones != cmd_count) begin
            $display("done pulsed %0d times for %0d commands", chk_dones, cmd_count);
            tb_errors++;
        end
        end_test("back-to-back random commands");

        $display("tests %0d, commands %0d, bytes checked %0d, errors %0d",
                 test_num, cmd_count, chk_reads, total_errors());
        if (total_errors() == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/panel_pkg.sv
hw/framebuffer_ram.sv
hw/fill_area_engine.sv
hw/cmd_fill.sv
hw/cmd_decoder.sv
hw/panel_cmd_top.sv
tb/panel_checker.sv
tb/tb_panel_cmd.sv

// ==== Makefile ====
# Verilator build and run for the LED panel command front end.

SRCS := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

obj_dir/Vtb_panel_cmd: $(SRCS) vlog.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_panel_cmd \
		-f vlog.f -o Vtb_panel_cmd

run: obj_dir/Vtb_panel_cmd
	obj_dir/Vtb_panel_cmd | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
